// File: src/be_isa_pkg.sv
// ISA and pipeline constants for the back-end hazard detector, shared by RTL and testbench
package be_isa_pkg;

  // register file geometry
  localparam int reg_addr_width_c = 5;
  localparam int num_regs_c = 32;

  // dependency pipe covers EX1 (stage 0) through EX4 (stage 3)
  localparam int dep_stages_c = 4;

  // stages searched for in-flight hazards, EX1 to EX3
  localparam int haz_stages_c = 3;

  typedef logic [reg_addr_width_c-1:0] reg_addr_t;

endpackage

// File: src/be_detector_pkg.sv
// Packed structs and the pipe enum that travel between the hazard detector modules
package be_detector_pkg;

  // execution unit an instruction is steered to
  typedef enum logic [2:0]
  {
    e_pipe_ctl  = 3'd0,
    e_pipe_int  = 3'd1,
    e_pipe_aux  = 3'd2,
    e_pipe_mul  = 3'd3,
    // early and final memory result paths
    e_pipe_emem = 3'd4,
    e_pipe_fmem = 3'd5,
    e_pipe_fma  = 3'd6
  } pipe_e;

  // instruction waiting in the issue slot
  typedef struct packed
  {
    be_isa_pkg::reg_addr_t rs1_addr;
    be_isa_pkg::reg_addr_t rs2_addr;
    be_isa_pkg::reg_addr_t rs3_addr;
    be_isa_pkg::reg_addr_t rd_addr;
    logic irs1_v;
    logic irs2_v;
    logic frs1_v;
    logic frs2_v;
    logic frs3_v;
    logic iwb_v;
    logic fwb_v;
    logic fence_v;
    logic mem_v;
    logic csr_v;
    logic long_v;
  } isd_status_s;

  // instruction that left the issue slot last cycle
  typedef struct packed
  {
    logic v;
    be_isa_pkg::reg_addr_t rd_addr;
    pipe_e pipe;
    logic irf_w_v;
    logic frf_w_v;
    logic mem_v;
    logic csr_v;
    logic fflags_w_v;
    // result comes back through the scoreboard
    logic late_iwb_v;
    logic late_fwb_v;
  } dispatch_pkt_s;

  // one execute stage of the dependency pipe
  typedef struct packed
  {
    logic instr_v;
    logic mem_v;
    logic fflags_w_v;
    logic aux_iwb_v;
    logic mul_iwb_v;
    logic emem_iwb_v;
    logic fmem_iwb_v;
    logic aux_fwb_v;
    logic emem_fwb_v;
    logic fmem_fwb_v;
    logic fma_fwb_v;
    be_isa_pkg::reg_addr_t rd_addr;
  } dep_status_s;

  // late writeback from a long-latency unit
  typedef struct packed
  {
    logic v;
    logic late;
    be_isa_pkg::reg_addr_t rd_addr;
  } wb_pkt_s;

  typedef struct packed
  {
    logic idiv_ready;
    logic fdiv_ready;
    logic mem_ready;
    logic ptw_busy;
    logic irq_pending;
    logic credits_full;
    logic credits_empty;
  } unit_status_s;

endpackage

// File: src/be_scoreboard.sv
// Pending-write scoreboard, one bit per register, matched against issue sources and destination
`timescale 1ns/1ps

module be_scoreboard
#(
  parameter int num_rs_p = 2
)
(
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  logic                                    score_v_i,
  input  be_isa_pkg::reg_addr_t                   score_rd_i,

  input  logic                                    clear_v_i,
  input  be_isa_pkg::reg_addr_t                   clear_rd_i,

  input  be_isa_pkg::reg_addr_t [num_rs_p-1:0]    rs_i,
  input  be_isa_pkg::reg_addr_t                   rd_i,
  output logic [num_rs_p-1:0]                     rs_match_o,
  output logic                                    rd_match_o
);

  logic [be_isa_pkg::num_regs_c-1:0] pending_r;
  logic [be_isa_pkg::num_regs_c-1:0] score_mask;
  logic [be_isa_pkg::num_regs_c-1:0] clear_mask;

  always_comb
  begin
    score_mask = '0;
    clear_mask = '0;
    score_mask[score_rd_i] = score_v_i;
    clear_mask[clear_rd_i] = clear_v_i;
  end

  // clear first, then score, so a same-cycle score on the register survives
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      pending_r <= '0;
    else
      pending_r <= (pending_r & ~clear_mask) | score_mask;
  end

  always_comb
  begin
    for (int i = 0; i < num_rs_p; i++)
      rs_match_o[i] = pending_r[rs_i[i]];
    rd_match_o = pending_r[rd_i];
  end

  // a late writeback only ever returns a result that was scored earlier
  clear_of_pending_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    clear_v_i |-> pending_r[clear_rd_i]
  ) else $error("scoreboard cleared register %0d that was not pending", clear_rd_i);

endmodule

// File: src/be_dep_pipe.sv
// Dependency pipe that tracks writers of each dispatched instruction through EX1 to EX4
`timescale 1ns/1ps

module be_dep_pipe
(
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  be_detector_pkg::dispatch_pkt_s dispatch_pkt_i,
  output be_detector_pkg::dep_status_s [be_isa_pkg::dep_stages_c-1:0] dep_stages_o
);

  be_detector_pkg::dep_status_s [be_isa_pkg::dep_stages_c-1:0] dep_stages_r;
  be_detector_pkg::dep_status_s dep_n;

  // decode pipe and register file write into per-unit writer flags
  always_comb
  begin
    dep_n = '0;
    dep_n.instr_v = 1'b1;
    dep_n.mem_v = dispatch_pkt_i.mem_v;
    dep_n.fflags_w_v = dispatch_pkt_i.fflags_w_v;
    dep_n.rd_addr = dispatch_pkt_i.rd_addr;
    case (dispatch_pkt_i.pipe)
      be_detector_pkg::e_pipe_aux:
      begin
        dep_n.aux_iwb_v = dispatch_pkt_i.irf_w_v;
        dep_n.aux_fwb_v = dispatch_pkt_i.frf_w_v;
      end
      be_detector_pkg::e_pipe_mul:
        dep_n.mul_iwb_v = dispatch_pkt_i.irf_w_v;
      be_detector_pkg::e_pipe_emem:
      begin
        dep_n.emem_iwb_v = dispatch_pkt_i.irf_w_v;
        dep_n.emem_fwb_v = dispatch_pkt_i.frf_w_v;
      end
      be_detector_pkg::e_pipe_fmem:
      begin
        dep_n.fmem_iwb_v = dispatch_pkt_i.irf_w_v;
        dep_n.fmem_fwb_v = dispatch_pkt_i.frf_w_v;
      end
      be_detector_pkg::e_pipe_fma:
        dep_n.fma_fwb_v = dispatch_pkt_i.frf_w_v;
      // ctl and int results forward from EX1, nothing to track
      default: ;
    endcase
  end

  // an empty slot enters as all zeros
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      dep_stages_r <= '0;
    else
    begin
      dep_stages_r[0] <= dispatch_pkt_i.v ? dep_n : '0;
      dep_stages_r[be_isa_pkg::dep_stages_c-1:1] <= dep_stages_r[be_isa_pkg::dep_stages_c-2:0];
    end
  end

  assign dep_stages_o = dep_stages_r;

  // bubbles must never alias register addresses in the hazard compare
  bubble_rd_zero_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !dep_stages_r[0].instr_v |-> (dep_stages_r[0].rd_addr == '0)
  ) else $error("EX1 bubble carries rd_addr %0d", dep_stages_r[0].rd_addr);

endmodule

// File: src/be_data_hazard.sv
// Data hazard check of the issue slot against the dependency pipe and both scoreboards
`timescale 1ns/1ps

module be_data_hazard
(
  input  be_detector_pkg::isd_status_s isd_status_i,
  input  be_detector_pkg::dep_status_s [be_isa_pkg::dep_stages_c-1:0] dep_stages_i,

  input  logic [1:0]                   irs_match_i,
  input  logic                         ird_match_i,
  input  logic [2:0]                   frs_match_i,
  input  logic                         frd_match_i,

  output logic                         data_haz_o
);

  be_isa_pkg::reg_addr_t [2:0] rs_addr;
  logic [1:0] irs_v;
  logic [2:0] frs_v;

  // per stage, whether a matching writer still lacks a forwardable result
  logic [be_isa_pkg::haz_stages_c-1:0] iwb_busy;
  logic [be_isa_pkg::haz_stages_c-1:0] fwb_busy;

  logic [1:0] irs_pipe_haz;
  logic [2:0] frs_pipe_haz;
  logic irs_sb_raw;
  logic ird_sb_waw;
  logic frs_sb_raw;
  logic frd_sb_waw;

  assign rs_addr = {isd_status_i.rs3_addr, isd_status_i.rs2_addr, isd_status_i.rs1_addr};

  // x0 is never a real dependency
  assign irs_v[0] = isd_status_i.irs1_v & (isd_status_i.rs1_addr != '0);
  assign irs_v[1] = isd_status_i.irs2_v & (isd_status_i.rs2_addr != '0);
  assign frs_v = {isd_status_i.frs3_v, isd_status_i.frs2_v, isd_status_i.frs1_v};

  always_comb
  begin
    // EX1, everything but ctl and int
    iwb_busy[0] = dep_stages_i[0].aux_iwb_v | dep_stages_i[0].mul_iwb_v
                | dep_stages_i[0].emem_iwb_v | dep_stages_i[0].fmem_iwb_v;
    fwb_busy[0] = dep_stages_i[0].aux_fwb_v | dep_stages_i[0].emem_fwb_v
                | dep_stages_i[0].fmem_fwb_v | dep_stages_i[0].fma_fwb_v;
    // EX2, final memory and multiply
    iwb_busy[1] = dep_stages_i[1].fmem_iwb_v | dep_stages_i[1].mul_iwb_v;
    fwb_busy[1] = dep_stages_i[1].fmem_fwb_v | dep_stages_i[1].fma_fwb_v;
    // EX3, only fma is still running
    iwb_busy[2] = 1'b0;
    fwb_busy[2] = dep_stages_i[2].fma_fwb_v;
  end

  always_comb
  begin
    irs_pipe_haz = '0;
    frs_pipe_haz = '0;
    for (int s = 0; s < be_isa_pkg::haz_stages_c; s++)
    begin
      for (int r = 0; r < 2; r++)
        irs_pipe_haz[r] = irs_pipe_haz[r]
                        | (irs_v[r] & iwb_busy[s] & (rs_addr[r] == dep_stages_i[s].rd_addr));
      for (int r = 0; r < 3; r++)
        frs_pipe_haz[r] = frs_pipe_haz[r]
                        | (frs_v[r] & fwb_busy[s] & (rs_addr[r] == dep_stages_i[s].rd_addr));
    end
  end

  // scoreboard RAW on sources, WAW on destination
  assign irs_sb_raw = |(irs_v & irs_match_i);
  assign ird_sb_waw = isd_status_i.iwb_v & ird_match_i & (isd_status_i.rd_addr != '0);
  assign frs_sb_raw = |(frs_v & frs_match_i);
  assign frd_sb_waw = isd_status_i.fwb_v & frd_match_i;

  assign data_haz_o = (|irs_pipe_haz) | (|frs_pipe_haz)
                    | irs_sb_raw | ird_sb_waw | frs_sb_raw | frd_sb_waw;

endmodule

// File: src/be_issue_gate.sv
// Control and structural hazard checks and the final dispatch and interrupt decision
`timescale 1ns/1ps

module be_issue_gate
(
  input  be_detector_pkg::isd_status_s  isd_status_i,
  input  be_detector_pkg::dep_status_s [be_isa_pkg::dep_stages_c-1:0] dep_stages_i,
  input  be_detector_pkg::unit_status_s unit_status_i,
  input  logic                          data_haz_i,

  output logic                          dispatch_v_o,
  output logic                          interrupt_v_o
);

  logic instr_in_pipe;
  logic mem_in_pipe;
  logic fflags_in_pipe;

  logic fence_haz;
  logic credit_haz;
  logic csr_haz;
  logic long_haz;
  logic fflags_haz;
  logic control_haz;
  logic struct_haz;

  always_comb
  begin
    instr_in_pipe = 1'b0;
    mem_in_pipe = 1'b0;
    fflags_in_pipe = 1'b0;
    for (int s = 0; s < be_isa_pkg::haz_stages_c; s++)
    begin
      instr_in_pipe = instr_in_pipe | dep_stages_i[s].instr_v;
      mem_in_pipe = mem_in_pipe | dep_stages_i[s].mem_v;
    end
    // fflags are written as late as EX4
    for (int s = 0; s < be_isa_pkg::dep_stages_c; s++)
      fflags_in_pipe = fflags_in_pipe | dep_stages_i[s].fflags_w_v;
  end

  // fence waits for memory to drain completely
  assign fence_haz = isd_status_i.fence_v
                   & (~unit_status_i.credits_empty | mem_in_pipe | ~unit_status_i.mem_ready);
  assign credit_haz = isd_status_i.mem_v & unit_status_i.credits_full;
  assign csr_haz = isd_status_i.csr_v & instr_in_pipe;
  assign long_haz = isd_status_i.long_v & instr_in_pipe;
  // CSR reads of fflags see every pending update, including the divider
  assign fflags_haz = isd_status_i.csr_v & (fflags_in_pipe | ~unit_status_i.fdiv_ready);

  assign control_haz = fence_haz | credit_haz | csr_haz | long_haz | fflags_haz;

  assign struct_haz = unit_status_i.ptw_busy
                    | (isd_status_i.mem_v & ~unit_status_i.mem_ready)
                    | (isd_status_i.long_v
                       & ~(unit_status_i.idiv_ready & unit_status_i.fdiv_ready));

  assign dispatch_v_o = ~(data_haz_i | control_haz | struct_haz);
  assign interrupt_v_o = unit_status_i.irq_pending & ~unit_status_i.ptw_busy;

  // a page walk owns the pipe, nothing issues under it
  always_comb
  begin
    ptw_blocks_dispatch_a: assert #0 (!(dispatch_v_o && unit_status_i.ptw_busy))
      else $error("dispatch granted while the PTW is busy");
  end

endmodule

// File: src/be_detector.sv
// Issue hazard detector top level, wiring scoreboards, dependency pipe and hazard checks
`timescale 1ns/1ps

module be_detector
(
  input  logic                           clk_i,
  input  logic                           reset_i,

  // issue slot, dispatch_v_o acts as its ready
  input  logic                           isd_v_i,
  input  be_detector_pkg::isd_status_s   isd_status_i,
  input  be_detector_pkg::dispatch_pkt_s dispatch_pkt_i,

  // late writebacks from the long-latency units
  input  be_detector_pkg::wb_pkt_s       iwb_pkt_i,
  input  be_detector_pkg::wb_pkt_s       fwb_pkt_i,

  input  be_detector_pkg::unit_status_s  unit_status_i,

  output logic                           dispatch_v_o,
  output logic                           interrupt_v_o
);

  be_detector_pkg::dep_status_s [be_isa_pkg::dep_stages_c-1:0] dep_stages;

  logic [1:0] irs_match;
  logic       ird_match;
  logic [2:0] frs_match;
  logic       frd_match;
  logic       data_haz;

  // isd_v_i only qualifies the handshake seen by the issue slot
  wire int_score_v = dispatch_pkt_i.v & dispatch_pkt_i.late_iwb_v;
  wire fp_score_v = dispatch_pkt_i.v & dispatch_pkt_i.late_fwb_v;
  wire int_clear_v = iwb_pkt_i.v & iwb_pkt_i.late;
  wire fp_clear_v = fwb_pkt_i.v & fwb_pkt_i.late;
  wire issue_fire = isd_v_i & dispatch_v_o;

  be_scoreboard
  #(
    .num_rs_p(2)
  )
  int_sb
  (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .score_v_i(int_score_v),
    .score_rd_i(dispatch_pkt_i.rd_addr),
    .clear_v_i(int_clear_v),
    .clear_rd_i(iwb_pkt_i.rd_addr),
    .rs_i({isd_status_i.rs2_addr, isd_status_i.rs1_addr}),
    .rd_i(isd_status_i.rd_addr),
    .rs_match_o(irs_match),
    .rd_match_o(ird_match)
  );

  be_scoreboard
  #(
    .num_rs_p(3)
  )
  fp_sb
  (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .score_v_i(fp_score_v),
    .score_rd_i(dispatch_pkt_i.rd_addr),
    .clear_v_i(fp_clear_v),
    .clear_rd_i(fwb_pkt_i.rd_addr),
    .rs_i({isd_status_i.rs3_addr, isd_status_i.rs2_addr, isd_status_i.rs1_addr}),
    .rd_i(isd_status_i.rd_addr),
    .rs_match_o(frs_match),
    .rd_match_o(frd_match)
  );

  be_dep_pipe dep_pipe
  (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .dispatch_pkt_i(dispatch_pkt_i),
    .dep_stages_o(dep_stages)
  );

  be_data_hazard data_hazard
  (
    .isd_status_i(isd_status_i),
    .dep_stages_i(dep_stages),
    .irs_match_i(irs_match),
    .ird_match_i(ird_match),
    .frs_match_i(frs_match),
    .frd_match_i(frd_match),
    .data_haz_o(data_haz)
  );

  be_issue_gate issue_gate
  (
    .isd_status_i(isd_status_i),
    .dep_stages_i(dep_stages),
    .unit_status_i(unit_status_i),
    .data_haz_i(data_haz),
    .dispatch_v_o(dispatch_v_o),
    .interrupt_v_o(interrupt_v_o)
  );

  // the issue slot sends a packet exactly one cycle after a granted issue
  dispatch_follows_issue_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    dispatch_pkt_i.v |-> $past(issue_fire)
  ) else $error("dispatch packet without a granted issue in the previous cycle");

endmodule

// File: tb/be_detector_tb.sv
// Testbench for the issue hazard detector, checks dispatch and interrupt against a shadow model
`timescale 1ns/1ps

module be_detector_tb;

  localparam int reset_cycles_c = 2;
  localparam int directed_cycles_c = 160;
  localparam int random_instrs_c = 150;
  // each random instruction is held at most 4 cycles plus one gap
  localparam int random_cycles_c = random_instrs_c * 6;
  localparam int timeout_c = 2 * (reset_cycles_c + directed_cycles_c + random_cycles_c);

  logic clk_i = 1'b0;
  logic reset_i;
  logic isd_v_i;
  be_detector_pkg::isd_status_s isd_status_i;
  be_detector_pkg::dispatch_pkt_s dispatch_pkt_i = '0;
  be_detector_pkg::wb_pkt_s iwb_pkt_i;
  be_detector_pkg::wb_pkt_s fwb_pkt_i;
  be_detector_pkg::unit_status_s unit_status_i;
  logic dispatch_v_o;
  logic interrupt_v_o;

  // packet that goes out the cycle after the current issue slot is granted
  be_detector_pkg::dispatch_pkt_s next_pkt;
  logic [15:0] lfsr_q = 16'd16877;
  int cycle_cnt = 0;

  // shadow dependency pipe and scoreboards
  logic m_v [4];
  logic m_mem [4];
  logic m_ff [4];
  logic m_iw [4];
  logic m_fw [4];
  be_detector_pkg::pipe_e m_pipe [4];
  be_isa_pkg::reg_addr_t m_rd [4];
  logic [31:0] m_isb;
  logic [31:0] m_fsb;
  logic exp_dispatch;
  logic exp_irq;

  be_detector be_detector_inst
  (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .isd_v_i(isd_v_i),
    .isd_status_i(isd_status_i),
    .dispatch_pkt_i(dispatch_pkt_i),
    .iwb_pkt_i(iwb_pkt_i),
    .fwb_pkt_i(fwb_pkt_i),
    .unit_status_i(unit_status_i),
    .dispatch_v_o(dispatch_v_o),
    .interrupt_v_o(interrupt_v_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > timeout_c)
    begin
      $display("timeout: the run did not finish within %0d cycles", timeout_c);
      $display("Errors found");
      $fatal(1);
    end
  end

  // the issue slot sends the packet of a granted instruction one cycle later
  always @(posedge clk_i)
  begin
    if (!reset_i && isd_v_i && dispatch_v_o)
      dispatch_pkt_i <= next_pkt;
    else
      dispatch_pkt_i <= '0;
  end

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < 4; s++)
      begin
        m_v[s] <= 1'b0;
        m_mem[s] <= 1'b0;
        m_ff[s] <= 1'b0;
        m_iw[s] <= 1'b0;
        m_fw[s] <= 1'b0;
        m_pipe[s] <= be_detector_pkg::e_pipe_ctl;
        m_rd[s] <= '0;
      end
      m_isb <= '0;
      m_fsb <= '0;
    end
    else
    begin
      for (int s = 1; s < 4; s++)
      begin
        m_v[s] <= m_v[s-1];
        m_mem[s] <= m_mem[s-1];
        m_ff[s] <= m_ff[s-1];
        m_iw[s] <= m_iw[s-1];
        m_fw[s] <= m_fw[s-1];
        m_pipe[s] <= m_pipe[s-1];
        m_rd[s] <= m_rd[s-1];
      end
      m_v[0] <= dispatch_pkt_i.v;
      m_mem[0] <= dispatch_pkt_i.v & dispatch_pkt_i.mem_v;
      m_ff[0] <= dispatch_pkt_i.v & dispatch_pkt_i.fflags_w_v;
      m_iw[0] <= dispatch_pkt_i.v & dispatch_pkt_i.irf_w_v;
      m_fw[0] <= dispatch_pkt_i.v & dispatch_pkt_i.frf_w_v;
      m_pipe[0] <= dispatch_pkt_i.v ? dispatch_pkt_i.pipe : be_detector_pkg::e_pipe_ctl;
      m_rd[0] <= dispatch_pkt_i.v ? dispatch_pkt_i.rd_addr : '0;
      m_isb <= sb_next(m_isb, dispatch_pkt_i.v & dispatch_pkt_i.late_iwb_v,
                       dispatch_pkt_i.rd_addr, iwb_pkt_i.v & iwb_pkt_i.late, iwb_pkt_i.rd_addr);
      m_fsb <= sb_next(m_fsb, dispatch_pkt_i.v & dispatch_pkt_i.late_fwb_v,
                       dispatch_pkt_i.rd_addr, fwb_pkt_i.v & fwb_pkt_i.late, fwb_pkt_i.rd_addr);
    end
  end

  // a score on the same register as a clear wins
  function automatic logic [31:0] sb_next(logic [31:0] sb, logic set_v, logic [4:0] set_rd,
                                          logic clr_v, logic [4:0] clr_rd);
    logic [31:0] r;
    r = sb;
    if (clr_v)
      r[clr_rd] = 1'b0;
    if (set_v)
      r[set_rd] = 1'b1;
    return r;
  endfunction

  always_comb
  begin
    logic haz;
    logic ib;
    logic fb;
    logic in_pipe;
    logic mem_pipe;
    logic ff_pipe;
    be_detector_pkg::isd_status_s st;
    be_detector_pkg::unit_status_s u;
    st = isd_status_i;
    u = unit_status_i;
    haz = 1'b0;
    in_pipe = 1'b0;
    mem_pipe = 1'b0;
    ff_pipe = 1'b0;
    for (int s = 0; s < 4; s++)
      ff_pipe = ff_pipe | m_ff[s];
    for (int s = 0; s < 3; s++)
    begin
      in_pipe = in_pipe | m_v[s];
      mem_pipe = mem_pipe | m_mem[s];
      ib = m_iw[s] && ((s == 0 && m_pipe[s] inside {be_detector_pkg::e_pipe_aux,
            be_detector_pkg::e_pipe_mul, be_detector_pkg::e_pipe_emem,
            be_detector_pkg::e_pipe_fmem})
          || (s == 1 && m_pipe[s] inside {be_detector_pkg::e_pipe_mul,
            be_detector_pkg::e_pipe_fmem}));
      fb = m_fw[s] && ((s == 0 && m_pipe[s] inside {be_detector_pkg::e_pipe_aux,
            be_detector_pkg::e_pipe_emem, be_detector_pkg::e_pipe_fmem,
            be_detector_pkg::e_pipe_fma})
          || (s == 1 && m_pipe[s] inside {be_detector_pkg::e_pipe_fmem,
            be_detector_pkg::e_pipe_fma})
          || (s == 2 && m_pipe[s] == be_detector_pkg::e_pipe_fma));
      if (ib && st.irs1_v && st.rs1_addr != 0 && st.rs1_addr == m_rd[s])
        haz = 1'b1;
      if (ib && st.irs2_v && st.rs2_addr != 0 && st.rs2_addr == m_rd[s])
        haz = 1'b1;
      if (fb && ((st.frs1_v && st.rs1_addr == m_rd[s]) || (st.frs2_v && st.rs2_addr == m_rd[s])
          || (st.frs3_v && st.rs3_addr == m_rd[s])))
        haz = 1'b1;
    end
    // scoreboards
    if ((st.irs1_v && st.rs1_addr != 0 && m_isb[st.rs1_addr])
        || (st.irs2_v && st.rs2_addr != 0 && m_isb[st.rs2_addr])
        || (st.iwb_v && st.rd_addr != 0 && m_isb[st.rd_addr]))
      haz = 1'b1;
    if ((st.frs1_v && m_fsb[st.rs1_addr]) || (st.frs2_v && m_fsb[st.rs2_addr])
        || (st.frs3_v && m_fsb[st.rs3_addr]) || (st.fwb_v && m_fsb[st.rd_addr]))
      haz = 1'b1;
    // control
    if (st.fence_v && (!u.credits_empty || mem_pipe || !u.mem_ready))
      haz = 1'b1;
    if (st.mem_v && u.credits_full)
      haz = 1'b1;
    if ((st.csr_v || st.long_v) && in_pipe)
      haz = 1'b1;
    if (st.csr_v && (ff_pipe || !u.fdiv_ready))
      haz = 1'b1;
    // structural
    if (u.ptw_busy || (st.mem_v && !u.mem_ready)
        || (st.long_v && !(u.idiv_ready && u.fdiv_ready)))
      haz = 1'b1;
    exp_dispatch = !haz;
    exp_irq = u.irq_pending && !u.ptw_busy;
  end

  dispatch_check_a: assert property (
    @(posedge clk_i) disable iff (reset_i) dispatch_v_o == exp_dispatch
  ) else
  begin
    $display("** Error at %0t: dispatch_v_o = %0b, expected %0b", $time,
             $sampled(dispatch_v_o), $sampled(exp_dispatch));
    $display("Errors found");
    $fatal(1);
  end

  interrupt_check_a: assert property (
    @(posedge clk_i) disable iff (reset_i) interrupt_v_o == exp_irq
  ) else
  begin
    $display("** Error at %0t: interrupt_v_o = %0b, expected %0b", $time,
             $sampled(interrupt_v_o), $sampled(exp_irq));
    $display("Errors found");
    $fatal(1);
  end

  // 16-bit Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic be_detector_pkg::unit_status_s units(logic idiv, logic fdiv, logic mem,
                                                          logic ptw, logic irq, logic full,
                                                          logic empty);
    be_detector_pkg::unit_status_s u;
    u.idiv_ready = idiv;
    u.fdiv_ready = fdiv;
    u.mem_ready = mem;
    u.ptw_busy = ptw;
    u.irq_pending = irq;
    u.credits_full = full;
    u.credits_empty = empty;
    return u;
  endfunction

  function automatic be_detector_pkg::isd_status_s int_op(int rs1, int rs2, int rd);
    be_detector_pkg::isd_status_s st;
    st = '0;
    st.rs1_addr = rs1[4:0];
    st.rs2_addr = rs2[4:0];
    st.rd_addr = rd[4:0];
    st.irs1_v = 1'b1;
    st.irs2_v = 1'b1;
    st.iwb_v = 1'b1;
    return st;
  endfunction

  function automatic be_detector_pkg::isd_status_s fp_op(int rs1, int rs2, int rs3, int rd);
    be_detector_pkg::isd_status_s st;
    st = '0;
    st.rs1_addr = rs1[4:0];
    st.rs2_addr = rs2[4:0];
    st.rs3_addr = rs3[4:0];
    st.rd_addr = rd[4:0];
    {st.frs1_v, st.frs2_v, st.frs3_v, st.fwb_v} = 4'b1111;
    return st;
  endfunction

  function automatic be_detector_pkg::dispatch_pkt_s pkt_for(be_detector_pkg::isd_status_s st,
                                                             be_detector_pkg::pipe_e pipe,
                                                             logic late);
    be_detector_pkg::dispatch_pkt_s p;
    p = '0;
    p.v = 1'b1;
    p.rd_addr = st.rd_addr;
    p.pipe = pipe;
    p.irf_w_v = st.iwb_v;
    p.frf_w_v = st.fwb_v;
    p.mem_v = st.mem_v;
    p.csr_v = st.csr_v;
    p.fflags_w_v = (pipe == be_detector_pkg::e_pipe_fma);
    p.late_iwb_v = late & st.iwb_v;
    p.late_fwb_v = late & st.fwb_v;
    return p;
  endfunction

  // hold an instruction in the issue slot until granted or for hold cycles,
  // then withdraw and leave one empty cycle so its packet reaches EX1
  task automatic present(input be_detector_pkg::isd_status_s st,
                         input be_detector_pkg::dispatch_pkt_s pk, input int hold);
    int n;
    logic granted;
    n = 0;
    granted = 1'b0;
    isd_v_i <= 1'b1;
    isd_status_i <= st;
    next_pkt <= pk;
    while (!granted && n < hold)
    begin
      @(posedge clk_i);
      granted = isd_v_i & dispatch_v_o;
      n++;
    end
    isd_v_i <= 1'b0;
    isd_status_i <= '0;
    @(posedge clk_i);
  endtask

  task automatic writeback(input logic fp, input int rd);
    if (fp)
      fwb_pkt_i <= {1'b1, 1'b1, rd[4:0]};
    else
      iwb_pkt_i <= {1'b1, 1'b1, rd[4:0]};
    @(posedge clk_i);
    iwb_pkt_i <= '0;
    fwb_pkt_i <= '0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  be_detector_pkg::unit_status_s idle_units;

  initial
  begin
    be_detector_pkg::isd_status_s st;
    logic [31:0] r;
    idle_units = units(1, 1, 1, 0, 0, 0, 1);
    reset_i = 1'b1;
    isd_v_i = 1'b0;
    isd_status_i = '0;
    next_pkt = '0;
    iwb_pkt_i = '0;
    fwb_pkt_i = '0;
    unit_status_i = idle_units;
    repeat (reset_cycles_c) @(posedge clk_i);
    reset_i <= 1'b0;
    idle(3);

    // in-flight writers in the dependency pipe
    present(int_op(1, 2, 5), pkt_for(int_op(1, 2, 5), be_detector_pkg::e_pipe_mul, 0), 4);
    present(int_op(5, 3, 6), pkt_for(int_op(5, 3, 6), be_detector_pkg::e_pipe_int, 0), 6);
    present(int_op(1, 2, 0), pkt_for(int_op(1, 2, 0), be_detector_pkg::e_pipe_mul, 0), 4);
    present(int_op(0, 0, 7), pkt_for(int_op(0, 0, 7), be_detector_pkg::e_pipe_int, 0), 4);
    present(fp_op(1, 2, 3, 4), pkt_for(fp_op(1, 2, 3, 4), be_detector_pkg::e_pipe_fma, 0), 4);
    present(fp_op(4, 4, 4, 8), pkt_for(fp_op(4, 4, 4, 8), be_detector_pkg::e_pipe_fma, 0), 6);
    idle(5);

    // late loads held in the scoreboards until written back
    st = int_op(1, 0, 9);
    st.mem_v = 1'b1;
    present(st, pkt_for(st, be_detector_pkg::e_pipe_emem, 1), 4);
    present(int_op(9, 2, 12), pkt_for(int_op(9, 2, 12), be_detector_pkg::e_pipe_int, 0), 8);
    present(int_op(3, 4, 9), pkt_for(int_op(3, 4, 9), be_detector_pkg::e_pipe_int, 0), 3);
    writeback(0, 9);
    present(int_op(9, 2, 12), pkt_for(int_op(9, 2, 12), be_detector_pkg::e_pipe_int, 0), 4);
    st = fp_op(1, 0, 0, 10);
    st.mem_v = 1'b1;
    present(st, pkt_for(st, be_detector_pkg::e_pipe_fmem, 1), 4);
    present(fp_op(3, 7, 10, 11), pkt_for(fp_op(3, 7, 10, 11), be_detector_pkg::e_pipe_fma, 0), 8);
    present(fp_op(1, 2, 3, 10), pkt_for(fp_op(1, 2, 3, 10), be_detector_pkg::e_pipe_fma, 0), 3);
    writeback(1, 10);
    present(fp_op(3, 7, 10, 11), pkt_for(fp_op(3, 7, 10, 11), be_detector_pkg::e_pipe_fma, 0), 4);
    idle(5);

    // control hazards
    present(int_op(1, 2, 3), pkt_for(int_op(1, 2, 3), be_detector_pkg::e_pipe_int, 0), 4);
    st = '0;
    st.csr_v = 1'b1;
    present(st, pkt_for(st, be_detector_pkg::e_pipe_ctl, 0), 8);
    st = int_op(1, 2, 13);
    st.long_v = 1'b1;
    present(st, pkt_for(st, be_detector_pkg::e_pipe_ctl, 0), 8);
    idle(4);
    unit_status_i <= units(1, 1, 1, 0, 0, 0, 0);
    st = '0;
    st.fence_v = 1'b1;
    present(st, pkt_for(st, be_detector_pkg::e_pipe_ctl, 0), 4);
    unit_status_i <= units(1, 1, 1, 0, 0, 1, 1);
    st = int_op(1, 0, 14);
    st.mem_v = 1'b1;
    present(st, pkt_for(st, be_detector_pkg::e_pipe_emem, 0), 4);
    unit_status_i <= idle_units;
    present(fp_op(1, 2, 3, 15), pkt_for(fp_op(1, 2, 3, 15), be_detector_pkg::e_pipe_fma, 0), 4);
    st = '0;
    st.csr_v = 1'b1;
    present(st, pkt_for(st, be_detector_pkg::e_pipe_ctl, 0), 8);

    // structural hazards and interrupt masking
    unit_status_i <= units(1, 1, 1, 1, 1, 0, 1);
    present(int_op(1, 2, 3), pkt_for(int_op(1, 2, 3), be_detector_pkg::e_pipe_int, 0), 4);
    unit_status_i <= units(1, 1, 0, 0, 1, 0, 1);
    st = int_op(1, 0, 16);
    st.mem_v = 1'b1;
    present(st, pkt_for(st, be_detector_pkg::e_pipe_emem, 0), 3);
    idle(4);
    unit_status_i <= units(0, 1, 1, 0, 0, 0, 1);
    st = int_op(1, 2, 17);
    st.long_v = 1'b1;
    present(st, pkt_for(st, be_detector_pkg::e_pipe_ctl, 0), 3);
    unit_status_i <= units(1, 0, 1, 0, 0, 0, 1);
    present(st, pkt_for(st, be_detector_pkg::e_pipe_ctl, 0), 3);
    unit_status_i <= idle_units;
    idle(4);

    // random instructions and unit status, no scoreboard traffic
    for (int i = 0; i < random_instrs_c; i++)
    begin
      r = take_bits(20);
      st = '0;
      {st.rs1_addr, st.rs2_addr, st.rs3_addr, st.rd_addr} = r[19:0];
      r = take_bits(11);
      {st.irs1_v, st.irs2_v, st.frs1_v, st.frs2_v, st.frs3_v, st.iwb_v, st.fwb_v} = r[6:0];
      st.fence_v = r[7] & r[8];
      st.mem_v = r[9];
      st.csr_v = r[10] & r[7];
      st.long_v = r[10] & ~r[7] & r[8];
      r = take_bits(7);
      unit_status_i <= units(r[0] | r[1], r[1] | r[2], r[2] | r[3], r[3] & r[4], r[5], r[6] & r[0],
                             r[4] | r[6]);
      r = take_bits(5);
      present(st, pkt_for(st, be_detector_pkg::pipe_e'(r[2:0] == 3'd7 ? 3'd1 : r[2:0]), 0),
              1 + int'(r[4:3]));
    end
    unit_status_i <= idle_units;
    idle(6);
    $display("No errors");
    $finish;
  end

endmodule

// File: compile.f
src/be_isa_pkg.sv
src/be_detector_pkg.sv
src/be_scoreboard.sv
src/be_dep_pipe.sv
src/be_data_hazard.sv
src/be_issue_gate.sv
src/be_detector.sv
tb/be_detector_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module be_detector_tb -o sim \
  && ./obj_dir/sim \
  || exit 1
